// ==== fe_pkg.sv ====
`default_nettype none

package fe_pkg;

    // Reset PC and the canonical NOP (andi r0, r0, 0)
    localparam logic [31:0] PC_RESET      = 32'h1c00_0000;
    localparam logic [31:0] INST_NOP      = 32'h0340_0000;
    localparam logic [31:0] BUBBLE_COOKIE = 32'd1958;

    // Fetch buffer geometry
    localparam int FB_DEPTH = 4;
    localparam int FB_PTR_W = $clog2(FB_DEPTH);
    // Count must also represent the full state
    localparam int FB_CNT_W = $clog2(FB_DEPTH + 1);

    // One fetch packet carries two instruction slots
    typedef struct packed {
        logic        bubble;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] pc;
        logic [31:0] pc_add;
        logic [31:0] pc_next;
        logic [31:0] badv;
        logic [31:0] cookie;
        logic [6:0]  exception;
        logic [1:0]  excp_flag;
        logic [1:0]  priv_flag;
    } fetch_pkt_t;

    // Packet loaded into the decode stage when there is nothing to decode
    localparam fetch_pkt_t BUBBLE_PKT = '{
        bubble:    1'b1,
        inst0:     INST_NOP,
        inst1:     INST_NOP,
        pc:        PC_RESET,
        pc_add:    PC_RESET + 32'd4,
        pc_next:   PC_RESET + 32'd8,
        badv:      PC_RESET,
        cookie:    BUBBLE_COOKIE,
        exception: 7'h00,
        excp_flag: 2'b00,
        priv_flag: 2'b00
    };

endpackage

`default_nettype wire

// ==== dec_pkg.sv ====
`default_nettype none

package dec_pkg;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD_W,
        OP_SUB_W,
        OP_ADDI_W,
        OP_LD_W,
        OP_ST_W,
        OP_BEQ,
        OP_B,
        OP_INVALID
    } opcode_e;

    // Major opcode fields, grouped by how many top bits they use
    // 3R format uses bits 31..15
    localparam logic [16:0] OPC17_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC17_SUB_W  = 17'h00022;
    // 2RI12 format uses bits 31..22
    localparam logic [9:0]  OPC10_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC10_LD_W   = 10'h0a2;
    localparam logic [9:0]  OPC10_ST_W   = 10'h0a6;
    // Branches use bits 31..26
    localparam logic [5:0]  OPC6_BEQ     = 6'h16;
    localparam logic [5:0]  OPC6_B       = 6'h14;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
        logic        ill;
    } dec_slot_t;

    typedef struct packed {
        dec_slot_t   slot0;
        dec_slot_t   slot1;
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] badv;
        logic [31:0] cookie;
        logic [6:0]  exception;
        logic [1:0]  excp_flag;
        logic [1:0]  priv_flag;
    } dec_pair_t;

endpackage

`default_nettype wire

// ==== fetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
    input  wire logic             clk,
    input  wire logic             arst_n,
    input  wire logic             flush,
    input  wire logic             in_valid,
    input  wire fe_pkg::fetch_pkt_t in_pkt,
    output logic                  in_allowin,
    output logic                  fb_valid,
    output fe_pkg::fetch_pkt_t    fb_pkt,
    input  wire logic             id_allowin
);
    import fe_pkg::*;

    fetch_pkt_t          mem [FB_DEPTH];
    logic [FB_PTR_W-1:0] wr_ptr;
    logic [FB_PTR_W-1:0] rd_ptr;
    logic [FB_CNT_W-1:0] count;
    logic                full;
    logic                wr_en;
    logic                rd_en;

    assign full     = (count == FB_CNT_W'(FB_DEPTH));
    assign fb_valid = (count != '0);
    // Head entry is presented straight from the array
    assign fb_pkt   = mem[rd_ptr];

    assign rd_en = fb_valid && id_allowin;
    // A slot freed by a read on the same edge may be refilled at once
    assign in_allowin = !flush && (!full || rd_en);
    assign wr_en      = in_valid && in_allowin;

    function automatic logic [FB_PTR_W-1:0] ptr_inc(input logic [FB_PTR_W-1:0] ptr);
        if (ptr == FB_PTR_W'(FB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_pkt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Writing over an unread head slot is only legal when the head leaves on the same edge
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wr_en && fb_valid && (wr_ptr == rd_ptr)) |-> rd_en
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        count <= FB_CNT_W'(FB_DEPTH)
    );

endmodule

`default_nettype wire

// ==== fifo_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_id_stage (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               flush,
    input  wire logic               fb_valid,
    input  wire fe_pkg::fetch_pkt_t fb_pkt,
    input  wire logic               id_allowin,
    output fe_pkg::fetch_pkt_t      id_pkt
);
    import fe_pkg::*;

    logic load_pkt;
    logic load_bubble;

    // Decode side is ready and the buffer has a real packet
    assign load_pkt    = id_allowin && fb_valid;
    // Nothing to hand on, so decode sees a NOP pair
    assign load_bubble = id_allowin && !fb_valid;

    // The stage is never empty
    // It holds either a real packet or the bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_pkt <= BUBBLE_PKT;
        end else if (flush) begin
            id_pkt <= BUBBLE_PKT;
        end else if (load_pkt) begin
            id_pkt <= fb_pkt;
        end else if (load_bubble) begin
            id_pkt <= BUBBLE_PKT;
        end
    end

    // Flushed work must not reach decode on the following cycle
    a_flush_bubble: assert property (
        @(posedge clk) disable iff (!arst_n)
        flush |=> (id_pkt.bubble && !fb_valid)
    );

endmodule

`default_nettype wire

// ==== inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire fe_pkg::fetch_pkt_t id_pkt,
    output dec_pkg::dec_pair_t      dec_pair
);
    import fe_pkg::*;
    import dec_pkg::*;

    function automatic dec_slot_t decode_slot(input logic [31:0] inst);
        dec_slot_t s;

        // Register fields sit at fixed positions in every format
        s.rd     = inst[4:0];
        s.rj     = inst[9:5];
        s.rk     = inst[14:10];
        s.imm    = '0;
        s.opcode = OP_INVALID;
        s.ill    = 1'b1;

        if (inst == INST_NOP) begin
            s.opcode = OP_NOP;
        end else if (inst[31:15] == OPC17_ADD_W) begin
            s.opcode = OP_ADD_W;
        end else if (inst[31:15] == OPC17_SUB_W) begin
            s.opcode = OP_SUB_W;
        end else if (inst[31:22] == OPC10_ADDI_W) begin
            s.opcode = OP_ADDI_W;
            s.imm    = {{20{inst[21]}}, inst[21:10]};
        end else if (inst[31:22] == OPC10_LD_W) begin
            s.opcode = OP_LD_W;
            s.imm    = {{20{inst[21]}}, inst[21:10]};
        end else if (inst[31:22] == OPC10_ST_W) begin
            s.opcode = OP_ST_W;
            s.imm    = {{20{inst[21]}}, inst[21:10]};
        end else if (inst[31:26] == OPC6_BEQ) begin
            // offs16 in words
            s.opcode = OP_BEQ;
            s.imm    = {{14{inst[25]}}, inst[25:10], 2'b00};
        end else if (inst[31:26] == OPC6_B) begin
            // offs26 is split, high part lives in bits 9..0
            s.opcode = OP_B;
            s.imm    = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end

        if (s.opcode != OP_INVALID) begin
            s.ill = 1'b0;
        end
        return s;
    endfunction

    always_comb begin
        dec_pair.slot0     = decode_slot(id_pkt.inst0);
        dec_pair.slot1     = decode_slot(id_pkt.inst1);
        dec_pair.pc        = id_pkt.pc;
        dec_pair.pc_next   = id_pkt.pc_next;
        dec_pair.badv      = id_pkt.badv;
        dec_pair.cookie    = id_pkt.cookie;
        dec_pair.exception = id_pkt.exception;
        dec_pair.excp_flag = id_pkt.excp_flag;
        dec_pair.priv_flag = id_pkt.priv_flag;
    end

endmodule

`default_nettype wire

// ==== decode_out_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_out_stage (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               flush,
    input  wire logic               id_pkt_bubble,
    input  wire dec_pkg::dec_pair_t dec_pair,
    output logic                    id_allowin,
    output logic                    out_valid,
    output dec_pkg::dec_pair_t      out_pair,
    input  wire logic               out_allowin
);

    logic accept;

    // Room when empty or when issue drains the current pair this cycle
    assign id_allowin = !out_valid || out_allowin;
    // Bubbles are consumed here and never become valid
    assign accept     = id_allowin && !id_pkt_bubble && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_allowin) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pair <= dec_pair;
        end
    end

    // Issue must see the same pair until it takes it
    a_stall_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (out_valid && !out_allowin) |=> $stable(out_pair)
    );

endmodule

`default_nettype wire

// ==== frontend_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_decode_top (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               flush,
    input  wire logic               in_valid,
    input  wire fe_pkg::fetch_pkt_t in_pkt,
    output logic                    in_allowin,
    output logic                    out_valid,
    output dec_pkg::dec_pair_t      out_pair,
    input  wire logic               out_allowin
);
    import fe_pkg::*;
    import dec_pkg::*;

    logic       fb_valid;
    fetch_pkt_t fb_pkt;
    logic       id_allowin;
    fetch_pkt_t id_pkt;
    dec_pair_t  dec_pair;

    fetch_buffer u_fetch_buffer (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .in_allowin (in_allowin),
        .fb_valid   (fb_valid),
        .fb_pkt     (fb_pkt),
        .id_allowin (id_allowin)
    );

    fifo_id_stage u_fifo_id_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .fb_valid   (fb_valid),
        .fb_pkt     (fb_pkt),
        .id_allowin (id_allowin),
        .id_pkt     (id_pkt)
    );

    inst_decoder u_inst_decoder (
        .id_pkt   (id_pkt),
        .dec_pair (dec_pair)
    );

    // Bubble flag travels beside the decoded pair
    decode_out_stage u_decode_out_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .id_pkt_bubble (id_pkt.bubble),
        .dec_pair      (dec_pair),
        .id_allowin    (id_allowin),
        .out_valid     (out_valid),
        .out_pair      (out_pair),
        .out_allowin   (out_allowin)
    );

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Release between edges so no register sees reset change on a clock edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_frontend_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frontend_decode;
    import fe_pkg::*;
    import dec_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int T_STREAM     = 3;
    localparam logic [1:0] ALLOW_HI  = 2'd0;
    localparam logic [1:0] ALLOW_LO  = 2'd1;
    localparam logic [1:0] ALLOW_RND = 2'd2;

    // Sample words and their register fields
    localparam logic [31:0] W_ADD  = 32'h0010_0823;  // add.w r3, r1, r2
    localparam logic [31:0] W_SUB  = 32'h0011_1cc5;  // sub.w r5, r6, r7
    localparam logic [31:0] W_ADDI = 32'h02bf_fca4;  // addi.w r4, r5, -1
    localparam logic [31:0] W_LD   = 32'h2880_40e6;  // ld.w r6, r7, 16
    localparam logic [31:0] W_ST   = 32'h299f_fd28;  // st.w r8, r9, 2047
    localparam logic [31:0] W_BEQ  = 32'h5bff_f022;  // beq r1, r2, -16
    localparam logic [31:0] W_BF   = 32'h5000_4000;  // b +64
    localparam logic [31:0] W_BB   = 32'h53ff_fbff;  // b -8
    localparam logic [31:0] W_BAD0 = 32'hffff_ffff;
    localparam logic [31:0] W_BAD1 = 32'h0000_0000;
    localparam logic [31:0] W_BAD2 = 32'h0020_0000;

    // One row is one clock cycle of fetch and issue activity
    typedef struct packed {
        logic [3:0]  test;
        logic        vld;
        logic        flush;
        logic [1:0]  allow;
        logic [31:0] pc;
        logic [31:0] inst0;
        opcode_e     op0;
        logic [31:0] imm0;
        logic [31:0] inst1;
        opcode_e     op1;
        logic [31:0] imm1;
    } row_t;

    logic       clk;
    logic       arst_n;
    logic       flush;
    logic       in_valid;
    fetch_pkt_t in_pkt;
    logic       in_allowin;
    logic       out_valid;
    dec_pair_t  out_pair;
    logic       out_allowin;

    row_t      rows[$];
    int        sb[$];
    int        errors;
    int        checks;
    int        test_base;
    int        cur_test;
    int        cycles;
    int        cycle_limit;
    integer    seed;
    logic      stalled;
    logic      prev_out_xfer;
    logic      full_seen;
    dec_pair_t stall_pair;

    tb_clkgen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    frontend_decode_top dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_pkt      (in_pkt),
        .in_allowin  (in_allowin),
        .out_valid   (out_valid),
        .out_pair    (out_pair),
        .out_allowin (out_allowin)
    );

    function automatic fetch_pkt_t make_pkt(input int idx);
        fetch_pkt_t p;
        p.bubble    = 1'b0;
        p.inst0     = rows[idx].inst0;
        p.inst1     = rows[idx].inst1;
        p.pc        = rows[idx].pc;
        p.pc_add    = rows[idx].pc + 32'd4;
        p.pc_next   = rows[idx].pc + 32'd8;
        p.badv      = rows[idx].pc;
        p.cookie    = 32'hc0de_0000 + 32'(idx);
        p.exception = 7'(idx * 3);
        p.excp_flag = 2'(idx);
        p.priv_flag = 2'(idx >> 2);
        return p;
    endfunction

    // Register fields come from fixed bit positions of the word
    function automatic dec_slot_t expect_slot(input logic [31:0] word, input opcode_e op,
                                              input logic [31:0] imm);
        dec_slot_t s;
        s.opcode = op;
        s.rd     = word[4:0];
        s.rj     = word[9:5];
        s.rk     = word[14:10];
        s.imm    = imm;
        s.ill    = (op == OP_INVALID);
        return s;
    endfunction

    function automatic dec_pair_t expect_pair(input int idx);
        dec_pair_t  e;
        fetch_pkt_t p;
        p           = make_pkt(idx);
        e.slot0     = expect_slot(p.inst0, rows[idx].op0, rows[idx].imm0);
        e.slot1     = expect_slot(p.inst1, rows[idx].op1, rows[idx].imm1);
        e.pc        = p.pc;
        e.pc_next   = p.pc_next;
        e.badv      = p.badv;
        e.cookie    = p.cookie;
        e.exception = p.exception;
        e.excp_flag = p.excp_flag;
        e.priv_flag = p.priv_flag;
        return e;
    endfunction

    task automatic check_slot(input string name, input dec_slot_t got, input dec_slot_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pair_side(input string name, input dec_pair_t got, input dec_pair_t exp);
        dec_pair_t g;
        dec_pair_t e;
        g       = got;
        e       = exp;
        g.slot0 = '0;
        g.slot1 = '0;
        e.slot0 = '0;
        e.slot1 = '0;
        checks++;
        if (g !== e) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, g, e);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input logic vld, input logic fl, input logic [1:0] allow,
                           input logic [31:0] i0, input opcode_e o0, input logic [31:0] m0,
                           input logic [31:0] i1, input opcode_e o1, input logic [31:0] m1);
        row_t r;
        r.test  = 4'(cur_test);
        r.vld   = vld;
        r.flush = fl;
        r.allow = allow;
        r.pc    = 32'h1c00_1000 + 32'(rows.size() * 8);
        r.inst0 = i0;
        r.op0   = o0;
        r.imm0  = m0;
        r.inst1 = i1;
        r.op1   = o1;
        r.imm1  = m1;
        rows.push_back(r);
    endtask

    task automatic add_pair(input logic [1:0] allow,
                            input logic [31:0] i0, input opcode_e o0, input logic [31:0] m0,
                            input logic [31:0] i1, input opcode_e o1, input logic [31:0] m1);
        add_row(1'b1, 1'b0, allow, i0, o0, m0, i1, o1, m1);
    endtask

    task automatic add_idle(input int n);
        for (int i = 0; i < n; i++) begin
            add_row(1'b0, 1'b0, ALLOW_HI, INST_NOP, OP_NOP, '0, INST_NOP, OP_NOP, '0);
        end
    endtask

    task automatic build_table();
        cur_test = 1;
        add_idle(6);
        cur_test = 2;
        add_pair(ALLOW_HI, INST_NOP, OP_NOP, 32'h0, W_ADD, OP_ADD_W, 32'h0);
        add_pair(ALLOW_HI, W_SUB, OP_SUB_W, 32'h0, W_ADDI, OP_ADDI_W, 32'hffff_ffff);
        add_pair(ALLOW_HI, W_LD, OP_LD_W, 32'h10, W_ST, OP_ST_W, 32'h7ff);
        add_pair(ALLOW_HI, W_BEQ, OP_BEQ, 32'hffff_fff0, W_BF, OP_B, 32'h40);
        add_pair(ALLOW_HI, W_BB, OP_B, 32'hffff_fff8, W_ADD, OP_ADD_W, 32'h0);
        add_idle(4);
        cur_test = T_STREAM;
        for (int i = 0; i < 12; i++) begin
            add_pair(ALLOW_HI, W_ADD, OP_ADD_W, 32'h0, W_LD, OP_LD_W, 32'h10);
        end
        add_idle(4);
        // Issue blocked from an empty pipeline, then random stalls
        cur_test = 4;
        for (int i = 0; i < FB_DEPTH + 4; i++) begin
            add_pair(ALLOW_LO, W_SUB, OP_SUB_W, 32'h0, W_ST, OP_ST_W, 32'h7ff);
        end
        for (int i = 0; i < 24; i++) begin
            add_pair(ALLOW_RND, W_ADDI, OP_ADDI_W, 32'hffff_ffff, W_BEQ, OP_BEQ, 32'hffff_fff0);
        end
        add_idle(10);
        cur_test = 5;
        for (int i = 0; i < 6; i++) begin
            add_pair(i < 3 ? ALLOW_HI : ALLOW_LO, W_LD, OP_LD_W, 32'h10, W_ADD, OP_ADD_W, 32'h0);
        end
        // Offered while flush is high, so it must be refused
        add_row(1'b1, 1'b1, ALLOW_LO, W_SUB, OP_SUB_W, 32'h0, W_SUB, OP_SUB_W, 32'h0);
        for (int i = 0; i < 5; i++) begin
            add_pair(ALLOW_HI, W_BF, OP_B, 32'h40, W_BB, OP_B, 32'hffff_fff8);
        end
        add_idle(6);
        cur_test = 6;
        add_pair(ALLOW_HI, W_BAD0, OP_INVALID, 32'h0, W_ADD, OP_ADD_W, 32'h0);
        add_pair(ALLOW_HI, INST_NOP, OP_NOP, 32'h0, W_BAD1, OP_INVALID, 32'h0);
        add_pair(ALLOW_HI, W_BAD2, OP_INVALID, 32'h0, W_BAD0, OP_INVALID, 32'h0);
        add_idle(6);
    endtask

    task automatic apply_row(input int idx);
        row_t        r;
        logic [31:0] rnd;
        int          exp_idx;
        dec_pair_t   exp_pair;
        r = rows[idx];
        @(negedge clk);
        rnd         = $random(seed);
        in_valid    = r.vld;
        in_pkt      = make_pkt(idx);
        flush       = r.flush;
        out_allowin = (r.allow == ALLOW_HI) || ((r.allow == ALLOW_RND) && rnd[0]);
        #1;
        // Nothing owed means an idle, ready pipeline
        if (!flush && sb.size() == 0) begin
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("in_allowin", in_allowin, 1'b1);
        end
        if (flush) begin
            check_bit("in_allowin", in_allowin, 1'b0);
        end
        if (stalled && out_valid) begin
            check_slot("out_pair.slot0 while stalled", out_pair.slot0, stall_pair.slot0);
            check_slot("out_pair.slot1 while stalled", out_pair.slot1, stall_pair.slot1);
            check_pair_side("out_pair side while stalled", out_pair, stall_pair);
        end
        if (int'(r.test) == T_STREAM && prev_out_xfer && sb.size() != 0 && !out_valid) begin
            errors++;
            $display("Gap in the output stream at %0t with packets still owed", $time);
        end
        if (in_valid && !in_allowin && !flush) begin
            full_seen = 1'b1;
            if (r.allow == ALLOW_LO) begin
                check_count("packets held", sb.size(), FB_DEPTH + 2);
            end else if (sb.size() < FB_DEPTH + 1) begin
                errors++;
                $display("in_allowin low at %0t with only %0d packets held", $time, sb.size());
            end
        end
        prev_out_xfer = out_valid && out_allowin;
        stalled       = out_valid && !out_allowin;
        stall_pair    = out_pair;
        if (out_valid && out_allowin && sb.size() != 0) begin
            exp_idx  = sb.pop_front();
            exp_pair = expect_pair(exp_idx);
            check_slot("out_pair.slot0", out_pair.slot0, exp_pair.slot0);
            check_slot("out_pair.slot1", out_pair.slot1, exp_pair.slot1);
            check_pair_side("out_pair side", out_pair, exp_pair);
        end
        if (in_valid && in_allowin) begin
            sb.push_back(idx);
        end
        if (flush) begin
            sb.delete();
        end
        if (sb.size() > FB_DEPTH + 2) begin
            errors++;
            $display("More than %0d packets in flight at %0t", FB_DEPTH + 2, $time);
        end
    endtask

    function automatic string test_title(input int t);
        case (t)
            1:       return "reset and idle";
            2:       return "decode of each kind";
            3:       return "ordered stream";
            4:       return "back-pressure and random stalls";
            5:       return "flush mid-stream";
            6:       return "unknown words";
            default: return "unnamed";
        endcase
    endfunction

    task automatic report_test(input int t);
        if (errors == test_base) begin
            $display("test %0d %s: ok", t, test_title(t));
        end else begin
            $display("test %0d %s: %0d errors", t, test_title(t), errors - test_base);
        end
    endtask

    // Watchdog sized from the table length
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: run did not end within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        flush         = 1'b0;
        in_valid      = 1'b0;
        in_pkt        = '0;
        out_allowin   = 1'b1;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        seed          = 32'h009277d4;
        stalled       = 1'b0;
        prev_out_xfer = 1'b0;
        full_seen     = 1'b0;
        build_table();
        cycle_limit = rows.size() * (FB_DEPTH + 4) + RESET_CYCLES;
        @(posedge arst_n);
        cur_test  = 0;
        test_base = 0;
        for (int i = 0; i < rows.size(); i++) begin
            if (int'(rows[i].test) != cur_test) begin
                if (cur_test != 0) begin
                    report_test(cur_test);
                end
                cur_test  = int'(rows[i].test);
                test_base = errors;
            end
            apply_row(i);
        end
        if (sb.size() != 0) begin
            errors++;
            $display("%0d accepted packets never reached the output", sb.size());
        end
        if (!full_seen) begin
            errors++;
            $display("in_allowin never dropped under back-pressure");
        end
        report_test(cur_test);
        $display("Summary: %0d tests, %0d checks, %0d errors", cur_test, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
fe_pkg.sv
dec_pkg.sv
fetch_buffer.sv
fifo_id_stage.sv
inst_decoder.sv
decode_out_stage.sv
frontend_decode_top.sv
tb_clkgen.sv
tb_frontend_decode.sv

// ==== Makefile ====
TOP := tb_frontend_decode

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
